// File: logic/mshr_pkg.sv
// Shared widths, MSHR geometry and vector types; imported by the miss unit RTL and its testbench
package mshr_pkg;

    // Cache line addressing
    localparam int CACHE_SET_W = 6;
    localparam int TAG_W       = 14;
    localparam int NLINE_W     = 20;

    // MSHR geometry, set taken from the low line bits
    localparam int MSHR_SETS   = 4;
    localparam int MSHR_SET_W  = 2;
    localparam int MSHR_WAYS   = 2;
    localparam int MSHR_WAY_W  = 1;
    localparam int MSHR_ID_W   = MSHR_WAY_W + MSHR_SET_W;

    // Request fields
    localparam int REQ_ID_W    = 4;
    localparam int WORD_W      = 3;

    // Tag, request id, word index and need-response flag
    localparam int MSHR_ENTRY_W = 22;

    typedef logic [NLINE_W-1:0]     nline_t;
    typedef logic [CACHE_SET_W-1:0] cache_set_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [REQ_ID_W-1:0]    req_id_t;
    typedef logic [WORD_W-1:0]      word_idx_t;
    typedef logic [MSHR_SET_W-1:0]  mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0]  mshr_way_t;

    // Way in the high bit, MSHR set below
    typedef logic [MSHR_ID_W-1:0]   mshr_id_t;

    // Packed payload with the tag on top and need-response in bit 0
    typedef logic [MSHR_ENTRY_W-1:0] mshr_entry_t;

endpackage

// File: logic/mshr_sram_wmask.sv
// Single-port synchronous RAM with a per-bit write mask; holds the MSHR entry payloads
`timescale 1ns/100ps

module mshr_sram_wmask #(
    parameter int DATA_W = 44,
    parameter int DEPTH  = 4
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [DATA_W-1:0]        wmask_i,
    input  logic [DATA_W-1:0]        wdata_i,
    output logic [DATA_W-1:0]        rdata_o
);

    logic [DATA_W-1:0] mem_q [DEPTH];

    // Masked write, unmasked bits keep their old value
    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
        end
    end

    // Read port output register
    // Held across writes and idle cycles like a macro's output latch
    always_ff @(posedge clk_i) begin
        if (cs_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// File: logic/mshr.sv
// MSHR file with set-associative entries; two-stage hit check, allocation and acknowledge readback
`timescale 1ns/100ps

module mshr
    import mshr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    output logic      empty_o,
    output logic      full_o,

    // Check
    input  logic      check_i,
    input  nline_t    check_nline_i,
    output logic      hit_o,

    // Allocation
    input  logic      alloc_i,
    input  nline_t    alloc_nline_i,
    input  req_id_t   alloc_req_id_i,
    input  word_idx_t alloc_word_i,
    input  logic      alloc_need_rsp_i,
    output logic      alloc_full_o,
    output mshr_way_t alloc_way_o,

    // Acknowledge
    input  logic      ack_i,
    input  mshr_id_t  ack_id_i,
    output req_id_t   ack_req_id_o,
    output word_idx_t ack_word_o,
    output logic      ack_need_rsp_o,
    output nline_t    ack_nline_o
);

    logic [MSHR_SETS*MSHR_WAYS-1:0] valid_q;
    cache_set_t                     cache_set_q [MSHR_SETS*MSHR_WAYS];

    cache_set_t check_cache_set_q;
    mshr_id_t   ack_id_q;

    mshr_set_t  check_set_st0;
    mshr_set_t  check_set_st1;
    mshr_set_t  alloc_set;
    mshr_set_t  ack_set;
    mshr_id_t   alloc_slot;
    mshr_way_t  ack_way;
    tag_t       check_tag;
    mshr_entry_t alloc_entry;

    logic                                   ram_cs;
    logic                                   ram_we;
    mshr_set_t                              ram_addr;
    logic [MSHR_WAYS-1:0][MSHR_ENTRY_W-1:0] ram_wmask;
    mshr_entry_t [MSHR_WAYS-1:0]            ram_wdata;
    mshr_entry_t [MSHR_WAYS-1:0]            ram_rdata;

    assign check_set_st0 = check_nline_i[MSHR_SET_W-1:0];
    assign check_set_st1 = check_cache_set_q[MSHR_SET_W-1:0];
    assign check_tag     = check_nline_i[NLINE_W-1 -: TAG_W];
    assign alloc_set     = alloc_nline_i[MSHR_SET_W-1:0];
    assign alloc_slot    = {alloc_way_o, alloc_set};
    assign ack_set       = ack_id_i[MSHR_SET_W-1:0];
    assign ack_way       = ack_id_q[MSHR_SET_W +: MSHR_WAY_W];

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    // Lowest free way wins, so scan downwards
    always_comb begin
        alloc_way_o = '0;
        for (int w = MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w*MSHR_SETS + alloc_set]) begin
                alloc_way_o = mshr_way_t'(w);
            end
        end
    end

    // Second check stage with the RAM tags now valid
    always_comb begin
        hit_o        = 1'b0;
        alloc_full_o = 1'b1;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            if (!valid_q[w*MSHR_SETS + check_set_st1]) begin
                alloc_full_o = 1'b0;
            end else if (cache_set_q[w*MSHR_SETS + check_set_st1] == check_cache_set_q &&
                         ram_rdata[w][MSHR_ENTRY_W-1 -: TAG_W] == check_tag) begin
                hit_o = 1'b1;
            end
        end
    end

    // Payload goes to every slice and the mask picks the way
    assign alloc_entry = {alloc_nline_i[NLINE_W-1 -: TAG_W], alloc_req_id_i,
                          alloc_word_i, alloc_need_rsp_i};
    assign ram_wdata   = {MSHR_WAYS{alloc_entry}};

    always_comb begin
        for (int w = 0; w < MSHR_WAYS; w++) begin
            ram_wmask[w] = {MSHR_ENTRY_W{alloc_way_o == mshr_way_t'(w)}};
        end
    end

    assign ram_cs   = check_i | alloc_i | ack_i;
    assign ram_we   = alloc_i;
    assign ram_addr = ack_i ? ack_set : (alloc_i ? alloc_set : check_set_st0);

    mshr_sram_wmask #(
        .DATA_W (MSHR_WAYS * MSHR_ENTRY_W),
        .DEPTH  (MSHR_SETS)
    ) sram_i (
        .clk_i   (clk_i),
        .cs_i    (ram_cs),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wmask_i (ram_wmask),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // Readback of the acknowledged way one cycle after the ack
    assign ack_req_id_o   = ram_rdata[ack_way][1 + WORD_W +: REQ_ID_W];
    assign ack_word_o     = ram_rdata[ack_way][1 +: WORD_W];
    assign ack_need_rsp_o = ram_rdata[ack_way][0];
    assign ack_nline_o    = {ram_rdata[ack_way][MSHR_ENTRY_W-1 -: TAG_W], cache_set_q[ack_id_q]};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q           <= '0;
            check_cache_set_q <= '0;
            ack_id_q          <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[alloc_slot] <= 1'b1;
            end
            if (ack_i) begin
                valid_q[ack_id_i] <= 1'b0;
                ack_id_q          <= ack_id_i;
            end
            if (check_i) begin
                check_cache_set_q <= check_nline_i[CACHE_SET_W-1:0];
            end
        end
    end

    // Cache set of each entry lives beside the RAM
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            cache_set_q[alloc_slot] <= alloc_nline_i[CACHE_SET_W-1:0];
        end
    end

endmodule

// File: logic/miss_ctrl.sv
// Miss controller FSM; sequences MSHR check, allocate and acknowledge and registers the results
`timescale 1ns/100ps

module miss_ctrl
    import mshr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Miss and refill strobes
    input  logic      miss_i,
    input  nline_t    miss_nline_i,
    input  req_id_t   miss_req_id_i,
    input  word_idx_t miss_word_i,
    input  logic      miss_need_rsp_i,
    input  logic      refill_i,
    input  mshr_id_t  refill_id_i,
    output logic      busy_o,

    // Outcome pulses
    output logic      miss_merged_o,
    output logic      miss_full_o,
    output logic      refill_req_o,
    output nline_t    refill_nline_o,
    output mshr_id_t  refill_id_o,

    // Core response
    output logic      rsp_valid_o,
    output req_id_t   rsp_req_id_o,
    output word_idx_t rsp_word_o,
    output nline_t    rsp_nline_o,

    // MSHR side
    output logic      check_o,
    output nline_t    check_nline_o,
    input  logic      hit_i,
    output logic      alloc_o,
    output nline_t    alloc_nline_o,
    output req_id_t   alloc_req_id_o,
    output word_idx_t alloc_word_o,
    output logic      alloc_need_rsp_o,
    input  logic      alloc_full_i,
    input  mshr_way_t alloc_way_i,
    output logic      ack_o,
    output mshr_id_t  ack_id_o,
    input  req_id_t   ack_req_id_i,
    input  word_idx_t ack_word_i,
    input  logic      ack_need_rsp_i,
    input  nline_t    ack_nline_i
);

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_DECIDE,
        MISS_RESPOND
    } miss_state_e;

    miss_state_e state_q;
    miss_state_e state_d;

    nline_t    line_q;
    req_id_t   req_id_q;
    word_idx_t word_q;
    logic      need_rsp_q;

    logic idle;
    logic decide;
    logic respond;

    assign idle    = (state_q == MISS_IDLE);
    assign decide  = (state_q == MISS_DECIDE);
    assign respond = (state_q == MISS_RESPOND);
    assign busy_o  = !idle;

    // Refill has priority over a miss in the same cycle
    assign ack_o    = idle && refill_i;
    assign ack_id_o = refill_id_i;
    assign check_o  = idle && miss_i && !refill_i;

    // First check stage sees the incoming line, the second the latched one
    assign check_nline_o    = decide ? line_q : miss_nline_i;
    assign alloc_nline_o    = line_q;
    assign alloc_req_id_o   = req_id_q;
    assign alloc_word_o     = word_q;
    assign alloc_need_rsp_o = need_rsp_q;
    assign alloc_o          = decide && !hit_i && !alloc_full_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE: begin
                if (ack_o) begin
                    state_d = MISS_RESPOND;
                end else if (check_o) begin
                    state_d = MISS_DECIDE;
                end
            end
            MISS_DECIDE:  state_d = MISS_IDLE;
            MISS_RESPOND: state_d = MISS_IDLE;
            default:      state_d = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= MISS_IDLE;
            miss_merged_o <= 1'b0;
            miss_full_o   <= 1'b0;
            refill_req_o  <= 1'b0;
            rsp_valid_o   <= 1'b0;
        end else begin
            state_q       <= state_d;
            miss_merged_o <= decide && hit_i;
            miss_full_o   <= decide && !hit_i && alloc_full_i;
            refill_req_o  <= alloc_o;
            rsp_valid_o   <= respond && ack_need_rsp_i;
        end
    end

    // Miss fields and result payloads
    always_ff @(posedge clk_i) begin
        if (check_o) begin
            line_q     <= miss_nline_i;
            req_id_q   <= miss_req_id_i;
            word_q     <= miss_word_i;
            need_rsp_q <= miss_need_rsp_i;
        end
        if (alloc_o) begin
            refill_nline_o <= line_q;
            refill_id_o    <= {alloc_way_i, line_q[MSHR_SET_W-1:0]};
        end
        if (respond) begin
            rsp_req_id_o <= ack_req_id_i;
            rsp_word_o   <= ack_word_i;
            rsp_nline_o  <= ack_nline_i;
        end
    end

endmodule

// File: logic/miss_unit.sv
// Miss handling top level; joins the miss controller to the MSHR file
`timescale 1ns/100ps

module miss_unit
    import mshr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      miss_i,
    input  nline_t    miss_nline_i,
    input  req_id_t   miss_req_id_i,
    input  word_idx_t miss_word_i,
    input  logic      miss_need_rsp_i,
    input  logic      refill_i,
    input  mshr_id_t  refill_id_i,
    output logic      busy_o,
    output logic      miss_merged_o,
    output logic      miss_full_o,
    output logic      refill_req_o,
    output nline_t    refill_nline_o,
    output mshr_id_t  refill_id_o,
    output logic      rsp_valid_o,
    output req_id_t   rsp_req_id_o,
    output word_idx_t rsp_word_o,
    output nline_t    rsp_nline_o,
    output logic      mshr_empty_o,
    output logic      mshr_full_o
);

    logic      check;
    nline_t    check_nline;
    logic      hit;
    logic      alloc;
    nline_t    alloc_nline;
    req_id_t   alloc_req_id;
    word_idx_t alloc_word;
    logic      alloc_need_rsp;
    logic      alloc_full;
    mshr_way_t alloc_way;
    logic      ack;
    mshr_id_t  ack_id;
    req_id_t   ack_req_id;
    word_idx_t ack_word;
    logic      ack_need_rsp;
    nline_t    ack_nline;

    miss_ctrl miss_ctrl_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .miss_i           (miss_i),
        .miss_nline_i     (miss_nline_i),
        .miss_req_id_i    (miss_req_id_i),
        .miss_word_i      (miss_word_i),
        .miss_need_rsp_i  (miss_need_rsp_i),
        .refill_i         (refill_i),
        .refill_id_i      (refill_id_i),
        .busy_o           (busy_o),
        .miss_merged_o    (miss_merged_o),
        .miss_full_o      (miss_full_o),
        .refill_req_o     (refill_req_o),
        .refill_nline_o   (refill_nline_o),
        .refill_id_o      (refill_id_o),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_req_id_o     (rsp_req_id_o),
        .rsp_word_o       (rsp_word_o),
        .rsp_nline_o      (rsp_nline_o),
        .check_o          (check),
        .check_nline_o    (check_nline),
        .hit_i            (hit),
        .alloc_o          (alloc),
        .alloc_nline_o    (alloc_nline),
        .alloc_req_id_o   (alloc_req_id),
        .alloc_word_o     (alloc_word),
        .alloc_need_rsp_o (alloc_need_rsp),
        .alloc_full_i     (alloc_full),
        .alloc_way_i      (alloc_way),
        .ack_o            (ack),
        .ack_id_o         (ack_id),
        .ack_req_id_i     (ack_req_id),
        .ack_word_i       (ack_word),
        .ack_need_rsp_i   (ack_need_rsp),
        .ack_nline_i      (ack_nline)
    );

    mshr mshr_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .empty_o          (mshr_empty_o),
        .full_o           (mshr_full_o),
        .check_i          (check),
        .check_nline_i    (check_nline),
        .hit_o            (hit),
        .alloc_i          (alloc),
        .alloc_nline_i    (alloc_nline),
        .alloc_req_id_i   (alloc_req_id),
        .alloc_word_i     (alloc_word),
        .alloc_need_rsp_i (alloc_need_rsp),
        .alloc_full_o     (alloc_full),
        .alloc_way_o      (alloc_way),
        .ack_i            (ack),
        .ack_id_i         (ack_id),
        .ack_req_id_o     (ack_req_id),
        .ack_word_o       (ack_word),
        .ack_need_rsp_o   (ack_need_rsp),
        .ack_nline_o      (ack_nline)
    );

endmodule

// File: test/miss_unit_model.svh
// Reference model of MSHR occupancy and outcome rules; included inside the miss unit testbench
`ifndef MISS_UNIT_MODEL_SVH
`define MISS_UNIT_MODEL_SVH

// One slot per entry id, indexed by way * sets + set
logic      entry_valid    [MSHR_SETS*MSHR_WAYS];
nline_t    entry_nline    [MSHR_SETS*MSHR_WAYS];
req_id_t   entry_req_id   [MSHR_SETS*MSHR_WAYS];
word_idx_t entry_word     [MSHR_SETS*MSHR_WAYS];
logic      entry_need_rsp [MSHR_SETS*MSHR_WAYS];

function automatic void reset_entries();
    for (int i = 0; i < MSHR_SETS * MSHR_WAYS; i++) begin
        entry_valid[i] = 1'b0;
    end
endfunction

// Index of the valid entry holding this line, or -1
function automatic int find_line(input nline_t line);
    for (int i = 0; i < MSHR_SETS * MSHR_WAYS; i++) begin
        if (entry_valid[i] && entry_nline[i] == line) begin
            return i;
        end
    end
    return -1;
endfunction

// Lowest way with a clear valid bit, or -1 when the set is full
function automatic int lowest_free_way(input int set);
    for (int w = 0; w < MSHR_WAYS; w++) begin
        if (!entry_valid[w*MSHR_SETS + set]) begin
            return w;
        end
    end
    return -1;
endfunction

function automatic mshr_id_t entry_id(input int way, input int set);
    return mshr_id_t'(way * MSHR_SETS + set);
endfunction

function automatic int valid_count();
    int n;
    n = 0;
    for (int i = 0; i < MSHR_SETS * MSHR_WAYS; i++) begin
        if (entry_valid[i]) begin
            n++;
        end
    end
    return n;
endfunction

`endif

// File: test/miss_unit_tb.sv
// Testbench for the miss unit; random misses and refills checked against an occupancy model
`timescale 1ns/100ps

module miss_unit_tb
    import mshr_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int OP_CYCLES    = 3;
    localparam int DIRECTED_OPS = 21;
    localparam int RAND_OPS     = 400;
    localparam int MARGIN_NS    = 2000;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 1 + (DIRECTED_OPS + RAND_OPS) * OP_CYCLES) * CLK_PERIOD + MARGIN_NS;
    localparam logic [31:0] SEED = 32'h4c235905;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      miss = 1'b0;
    nline_t    miss_nline = '0;
    req_id_t   miss_req_id = '0;
    word_idx_t miss_word = '0;
    logic      miss_need_rsp = 1'b0;
    logic      refill = 1'b0;
    mshr_id_t  refill_id = '0;

    logic      busy;
    logic      miss_merged;
    logic      miss_full;
    logic      refill_req;
    nline_t    refill_nline;
    mshr_id_t  refill_id_out;
    logic      rsp_valid;
    req_id_t   rsp_req_id;
    word_idx_t rsp_word;
    nline_t    rsp_nline;
    logic      mshr_empty;
    logic      mshr_full;

    int errors = 0;
    int errors_before = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_clean = 0;
    nline_t dir_lines [8];
    nline_t pool [12];
    int pick;

    `include "miss_unit_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    miss_unit miss_unit_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .miss_i          (miss),
        .miss_nline_i    (miss_nline),
        .miss_req_id_i   (miss_req_id),
        .miss_word_i     (miss_word),
        .miss_need_rsp_i (miss_need_rsp),
        .refill_i        (refill),
        .refill_id_i     (refill_id),
        .busy_o          (busy),
        .miss_merged_o   (miss_merged),
        .miss_full_o     (miss_full),
        .refill_req_o    (refill_req),
        .refill_nline_o  (refill_nline),
        .refill_id_o     (refill_id_out),
        .rsp_valid_o     (rsp_valid),
        .rsp_req_id_o    (rsp_req_id),
        .rsp_word_o      (rsp_word),
        .rsp_nline_o     (rsp_nline),
        .mshr_empty_o    (mshr_empty),
        .mshr_full_o     (mshr_full)
    );

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_pulses_low();
        check_hex("miss_merged_o", miss_merged, 0);
        check_hex("miss_full_o", miss_full, 0);
        check_hex("refill_req_o", refill_req, 0);
        check_hex("rsp_valid_o", rsp_valid, 0);
    endtask

    task automatic check_levels();
        check_hex("mshr_empty_o", mshr_empty, valid_count() == 0);
        check_hex("mshr_full_o", mshr_full, valid_count() == MSHR_SETS * MSHR_WAYS);
    endtask

    // Strobe during a busy cycle, the DUT must ignore it
    task automatic drive_noise();
        if ($urandom_range(1) == 0) begin
            miss       <= 1'b1;
            miss_nline <= nline_t'($urandom);
        end else begin
            refill    <= 1'b1;
            refill_id <= mshr_id_t'($urandom);
        end
    endtask

    // Second cycle of an operation, busy with no result yet
    task automatic wait_result(input bit noise);
        @(posedge clk);
        miss   <= 1'b0;
        refill <= 1'b0;
        if (noise) begin
            drive_noise();
        end
        @(negedge clk);
        check_hex("busy_o", busy, 1);
        check_pulses_low();
        @(posedge clk);
        miss   <= 1'b0;
        refill <= 1'b0;
        @(negedge clk);
        check_hex("busy_o", busy, 0);
    endtask

    task automatic do_miss(input nline_t line, input req_id_t req_id, input word_idx_t word,
                           input logic need_rsp, input bit noise);
        int       set;
        int       way;
        logic     exp_merged;
        logic     exp_full;
        mshr_id_t id;
        set        = int'(line[MSHR_SET_W-1:0]);
        way        = lowest_free_way(set);
        exp_merged = (find_line(line) >= 0);
        exp_full   = !exp_merged && (way < 0);
        @(posedge clk);
        miss          <= 1'b1;
        miss_nline    <= line;
        miss_req_id   <= req_id;
        miss_word     <= word;
        miss_need_rsp <= need_rsp;
        wait_result(noise);
        check_hex("miss_merged_o", miss_merged, exp_merged);
        check_hex("miss_full_o", miss_full, exp_full);
        check_hex("refill_req_o", refill_req, !exp_merged && !exp_full);
        check_hex("rsp_valid_o", rsp_valid, 0);
        if (!exp_merged && !exp_full) begin
            id = entry_id(way, set);
            check_hex("refill_nline_o", refill_nline, line);
            check_hex("refill_id_o", refill_id_out, id);
            entry_valid[id]    = 1'b1;
            entry_nline[id]    = line;
            entry_req_id[id]   = req_id;
            entry_word[id]     = word;
            entry_need_rsp[id] = need_rsp;
        end
        check_levels();
    endtask

    task automatic do_refill(input mshr_id_t id, input bit noise);
        @(posedge clk);
        refill    <= 1'b1;
        refill_id <= id;
        wait_result(noise);
        check_hex("rsp_valid_o", rsp_valid, entry_need_rsp[id]);
        check_hex("miss_merged_o", miss_merged, 0);
        check_hex("miss_full_o", miss_full, 0);
        check_hex("refill_req_o", refill_req, 0);
        if (entry_need_rsp[id]) begin
            check_hex("rsp_req_id_o", rsp_req_id, entry_req_id[id]);
            check_hex("rsp_word_o", rsp_word, entry_word[id]);
            check_hex("rsp_nline_o", rsp_nline, entry_nline[id]);
        end
        entry_valid[id] = 1'b0;
        check_levels();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            tests_clean++;
            $display("[%0d] %s: ok", tests_run, name);
        end else begin
            $display("[%0d] %s: %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset_entries();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_hex("busy_o", busy, 0);
        check_pulses_low();
        check_levels();
        finish_test("reset state");

        // Two lines per MSHR set fill every way
        for (int i = 0; i < 8; i++) begin
            dir_lines[i] = {tag_t'(($urandom << 3) | i),
                            cache_set_t'(($urandom_range(15) << 2) | (i % MSHR_SETS))};
            do_miss(dir_lines[i], req_id_t'($urandom), word_idx_t'($urandom),
                    $urandom_range(1) == 1, 1'b0);
        end
        finish_test("allocation");

        do_miss(dir_lines[2], 4'h3, 3'h5, 1'b1, 1'b0);
        do_miss({~dir_lines[2][NLINE_W-1 -: TAG_W], dir_lines[2][CACHE_SET_W-1:0]},
                4'h6, 3'h1, 1'b1, 1'b0);
        do_miss(dir_lines[7], 4'h9, 3'h2, 1'b0, 1'b0);
        finish_test("merge and full");

        for (int i = 0; i < 8; i++) begin
            do_refill(mshr_id_t'(i), 1'b0);
        end
        do_miss(dir_lines[5], 4'ha, 3'h7, 1'b1, 1'b0);
        do_refill(entry_id(0, 1), 1'b0);
        finish_test("refill and reuse");

        // Few lines per set so that merges and full sets are common
        for (int i = 0; i < 12; i++) begin
            pool[i] = {tag_t'($urandom),
                       cache_set_t'(($urandom_range(15) << 2) | (i % MSHR_SETS))};
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            if (valid_count() > 0 && $urandom_range(9) < 4) begin
                pick = $urandom_range(7);
                while (!entry_valid[pick]) begin
                    pick = (pick + 1) % 8;
                end
                do_refill(mshr_id_t'(pick), $urandom_range(1) == 1);
            end else begin
                do_miss(pool[$urandom_range(11)], req_id_t'($urandom), word_idx_t'($urandom),
                        $urandom_range(1) == 1, $urandom_range(1) == 1);
            end
        end
        finish_test("random mix");

        $display("%0d of %0d tests clean, %0d checks, %0d errors",
                 tests_clean, tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+test
logic/mshr_pkg.sv
logic/mshr_sram_wmask.sv
logic/mshr.sv
logic/miss_ctrl.sv
logic/miss_unit.sv
test/miss_unit_tb.sv
